//--- palette_lut.sv
// Colour index to 24-bit RGB through the shared palette table.
// One register stage, cleared to black on reset.

`timescale 1ns/1ps
`include "sprite_config.svh"

module palette_lut
	import sprite_pkg::*;
(
	input logic Clk50,
	input logic arst_n,
	input cidx_t idx,
	output chan_t red,
	output chan_t green,
	output chan_t blue
);

	always_ff @(posedge Clk50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end
		else
		begin
			// entry order is r, g, b
			red <= palette_table[idx][0];
			green <= palette_table[idx][1];
			blue <= palette_table[idx][2];
		end
	end

endmodule

//--- pixel_compositor.sv
// Final colour choice: black when blanked, grey background, or palette colour.
// Delays the stage-1 flags to meet the palette output.

`timescale 1ns/1ps
`include "sprite_config.svh"

module pixel_compositor
	import sprite_pkg::*;
(
	input logic Clk50,
	input logic arst_n,
	input logic s1_hit,
	input logic s1_valid,
	input logic s1_blank,
	input cidx_t idx,
	input chan_t pal_red,
	input chan_t pal_green,
	input chan_t pal_blue,
	output chan_t red,
	output chan_t green,
	output chan_t blue,
	output logic out_valid
);

	// stage 2, in step with the memory read data
	logic s2_hit;
	logic s2_valid;
	logic s2_blank;
	// stage 3, in step with the palette registers
	logic s3_black;
	logic s3_bg;

	// --------------------------------------------------
	// flag pipe and colour select
	// --------------------------------------------------
	always_ff @(posedge Clk50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s2_hit <= 1'b0;
			s2_valid <= 1'b0;
			s2_blank <= 1'b0;
			s3_black <= 1'b1;
			s3_bg <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			s2_hit <= s1_hit;
			s2_valid <= s1_valid;
			s2_blank <= s1_blank;
			// blank wins over everything
			s3_black <= s2_blank;
			// no sprite, or the winner is transparent here
			s3_bg <= !s2_hit || (idx == '0);
			out_valid <= s2_valid;
		end
	end

	// output mux after the palette register
	assign red = s3_black ? '0 : (s3_bg ? `BG_LEVEL : pal_red);
	assign green = s3_black ? '0 : (s3_bg ? `BG_LEVEL : pal_green);
	assign blue = s3_black ? '0 : (s3_bg ? `BG_LEVEL : pal_blue);

endmodule

//--- pixel_if.sv
// One raster pixel as seen by the sprite engines and the arbiter.
// Driven at the top level from plain ports.

`timescale 1ns/1ps
`include "sprite_config.svh"

interface pixel_if
	import sprite_pkg::*;
();

	// pixel qualifier and blanking
	logic valid;
	logic blank;

	// current draw position
	coord_t x;
	coord_t y;

	// engines only look at the position
	modport engine (input x, input y);

	// arbiter carries the flags into the pipe
	modport arb (input valid, input blank);

endinterface

//--- sources.f
+incdir+.
sprite_pkg.sv
pixel_if.sv
sprite_engine.sv
sprite_arbiter.sv
sprite_ram.sv
palette_lut.sv
pixel_compositor.sv
sprite_renderer_top.sv
tb_sprite_renderer_asserts.sv
tb_sprite_renderer.sv

//--- sprite_arbiter.sv
// Fixed-priority owner of the single sprite memory read port.
// Runner beats cactus beats cloud; the winner is registered as stage 1.

`timescale 1ns/1ps
`include "sprite_config.svh"

module sprite_arbiter
	import sprite_pkg::*;
(
	input logic Clk50,
	input logic arst_n,
	pixel_if.arb pix,
	input logic hit_runner,
	input logic hit_cactus,
	input logic hit_cloud,
	input spr_addr_t addr_runner,
	input spr_addr_t addr_cactus,
	input spr_addr_t addr_cloud,
	output spr_addr_t rd_addr,
	output logic s1_hit,
	output logic s1_valid,
	output logic s1_blank,
	output layer_e s1_layer
);

	spr_addr_t grant_addr;
	layer_e grant_layer;

	// --------------------------------------------------
	// priority select
	// --------------------------------------------------
	always_comb
	begin
		grant_addr = spr_addr_t'(`RUNNER_BASE);
		grant_layer = NONE;
		if (hit_runner)
		begin
			grant_addr = addr_runner;
			grant_layer = RUNNER;
		end
		else if (hit_cactus)
		begin
			grant_addr = addr_cactus;
			grant_layer = CACTUS;
		end
		else if (hit_cloud)
		begin
			grant_addr = addr_cloud;
			grant_layer = CLOUD;
		end
	end

	// stage 1 flags and layer tag
	always_ff @(posedge Clk50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s1_hit <= 1'b0;
			s1_valid <= 1'b0;
			s1_blank <= 1'b0;
			s1_layer <= NONE;
		end
		else
		begin
			s1_hit <= (grant_layer != NONE);
			s1_valid <= pix.valid;
			s1_blank <= pix.blank;
			s1_layer <= grant_layer;
		end
	end

	// read address, payload only
	always_ff @(posedge Clk50)
	begin
		rd_addr <= grant_addr;
	end

endmodule

//--- sprite_config.svh
// Shared sizing for the sprite renderer.
// Include in any file that needs widths, sprite geometry or memory bases.
// The package takes its type widths from here.

`ifndef SPRITE_CONFIG_SVH
`define SPRITE_CONFIG_SVH

// raster coordinate width
`define COORD_W 10

// sprite edge in pixels, square sprites
`define SPR_DIM 16

// sprite memory address and colour index
`define SPR_ADDR_W 10
`define CIDX_W 4

// region bases, one 16x16 block each
`define RUNNER_BASE 0
`define CACTUS_BASE 256
`define CLOUD_BASE 512

// colour channel and background grey
`define RGB_W 8
`define BG_LEVEL 8'hA0

// input pixel to output colour, in cycles
`define PIPE_LAT 3

`endif

//--- sprite_engine.sv
// Window test and address generation for one sprite.
// Combinational; one instance per sprite, BASE selects its memory region.

`timescale 1ns/1ps
`include "sprite_config.svh"

module sprite_engine
	import sprite_pkg::*;
#(
	parameter spr_addr_t BASE = '0
)
(
	pixel_if.engine pix,
	input coord_t pos_x,
	input coord_t pos_y,
	output logic hit,
	output spr_addr_t addr
);

	// bits of a row or column offset
	localparam int OFS_W = $clog2(`SPR_DIM);

	// one extra bit, top bit is the borrow
	logic [`COORD_W:0] dx;
	logic [`COORD_W:0] dy;
	logic in_x;
	logic in_y;

	// --------------------------------------------------
	// window test
	// --------------------------------------------------
	// pixel minus sprite origin, no wrap
	assign dx = {1'b0, pix.x} - {1'b0, pos_x};
	assign dy = {1'b0, pix.y} - {1'b0, pos_y};

	// borrow set means left of or above the sprite
	assign in_x = !dx[`COORD_W] && (dx < `SPR_DIM);
	assign in_y = !dy[`COORD_W] && (dy < `SPR_DIM);
	assign hit = in_x && in_y;

	// --------------------------------------------------
	// address, base + row*16 + column
	// --------------------------------------------------
	// power-of-two edge, so row and column just concatenate
	assign addr = BASE + spr_addr_t'({dy[OFS_W-1:0], dx[OFS_W-1:0]});

endmodule

//--- sprite_pkg.sv
// Types shared by the renderer modules and the testbench model.
// Import with a wildcard in the module header.

`include "sprite_config.svh"

package sprite_pkg;

	// widths with a meaning
	typedef logic [`COORD_W-1:0] coord_t;
	typedef logic [`SPR_ADDR_W-1:0] spr_addr_t;
	typedef logic [`CIDX_W-1:0] cidx_t;
	typedef logic [`RGB_W-1:0] chan_t;

	// granted layer, NONE when nothing covers the pixel
	typedef enum logic [1:0] {NONE, RUNNER, CACTUS, CLOUD} layer_e;

	// --------------------------------------------------
	// palette, entry is {red, green, blue}
	// index 0 is transparent, its entry never shows
	// --------------------------------------------------
	localparam chan_t palette_table [0:15][0:2] = '{
		'{8'h00, 8'h00, 8'h00}, '{8'h20, 8'h20, 8'h20},
		'{8'h53, 8'h53, 8'h53}, '{8'hF7, 8'hF7, 8'hF7},
		'{8'h2E, 8'h8B, 8'h57}, '{8'h6B, 8'hC0, 8'h4A},
		'{8'h1F, 8'h5F, 8'h2F}, '{8'hE0, 8'hE8, 8'hF0},
		'{8'hB0, 8'hC4, 8'hDE}, '{8'hD2, 8'h69, 8'h1E},
		'{8'hFF, 8'hD7, 8'h00}, '{8'hC0, 8'h30, 8'h30},
		'{8'h30, 8'h60, 8'hC0}, '{8'h8B, 8'h45, 8'h13},
		'{8'hFF, 8'hA0, 8'hB0}, '{8'hFF, 8'hFF, 8'hFF}
	};

endpackage

//--- sprite_ram.sv
// Sprite memory, three 16x16 regions of 4-bit colour indices.
// Registered read for the pixel pipe, separate write port for host loads.

`timescale 1ns/1ps
`include "sprite_config.svh"

module sprite_ram
	import sprite_pkg::*;
(
	input logic Clk50,
	input spr_addr_t rd_addr,
	output cidx_t rd_data,
	input logic we,
	input spr_addr_t wr_addr,
	input cidx_t wr_data
);

	// runner, cactus and cloud regions
	localparam int DEPTH = 3 * `SPR_DIM * `SPR_DIM;

	cidx_t mem [0:DEPTH-1];

	// host load port
	always_ff @(posedge Clk50)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// pipe read port
	// same-cycle write to the read address returns old data
	always_ff @(posedge Clk50)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- sprite_renderer_top.sv
// Sprite pixel renderer for the runner game.
// One pixel in per Clk50 cycle, its colour out three cycles later.
// The host fills sprite memory through the load port before streaming.

`timescale 1ns/1ps
`include "sprite_config.svh"

module sprite_renderer_top
	import sprite_pkg::*;
(
	input logic Clk50,
	input logic arst_n,
	input logic pix_valid,
	input logic blank,
	input coord_t draw_x,
	input coord_t draw_y,
	input coord_t runner_x,
	input coord_t runner_y,
	input coord_t cactus_x,
	input coord_t cactus_y,
	input coord_t cloud_x,
	input coord_t cloud_y,
	input logic load_we,
	input spr_addr_t load_addr,
	input cidx_t load_data,
	output chan_t red,
	output chan_t green,
	output chan_t blue,
	output logic out_valid
);

	logic hit_runner;
	logic hit_cactus;
	logic hit_cloud;
	spr_addr_t addr_runner;
	spr_addr_t addr_cactus;
	spr_addr_t addr_cloud;
	spr_addr_t rd_addr;
	logic s1_hit;
	logic s1_valid;
	logic s1_blank;
	layer_e s1_layer;
	cidx_t idx;
	chan_t pal_red;
	chan_t pal_green;
	chan_t pal_blue;

	// --------------------------------------------------
	// raster pixel
	// --------------------------------------------------
	pixel_if pix ();

	assign pix.valid = pix_valid;
	assign pix.blank = blank;
	assign pix.x = draw_x;
	assign pix.y = draw_y;

	// one engine per sprite, region picked by BASE
	sprite_engine #(.BASE(spr_addr_t'(`RUNNER_BASE))) u_runner (
		.pix(pix), .pos_x(runner_x), .pos_y(runner_y),
		.hit(hit_runner), .addr(addr_runner)
	);
	sprite_engine #(.BASE(spr_addr_t'(`CACTUS_BASE))) u_cactus (
		.pix(pix), .pos_x(cactus_x), .pos_y(cactus_y),
		.hit(hit_cactus), .addr(addr_cactus)
	);
	sprite_engine #(.BASE(spr_addr_t'(`CLOUD_BASE))) u_cloud (
		.pix(pix), .pos_x(cloud_x), .pos_y(cloud_y),
		.hit(hit_cloud), .addr(addr_cloud)
	);

	// --------------------------------------------------
	// pipe, edge 1 arbiter, edge 2 memory, edge 3 colour
	// --------------------------------------------------
	sprite_arbiter u_arbiter (
		.Clk50(Clk50), .arst_n(arst_n), .pix(pix),
		.hit_runner(hit_runner), .hit_cactus(hit_cactus), .hit_cloud(hit_cloud),
		.addr_runner(addr_runner), .addr_cactus(addr_cactus), .addr_cloud(addr_cloud),
		.rd_addr(rd_addr), .s1_hit(s1_hit), .s1_valid(s1_valid),
		.s1_blank(s1_blank), .s1_layer(s1_layer)
	);

	sprite_ram u_ram (
		.Clk50(Clk50), .rd_addr(rd_addr), .rd_data(idx),
		.we(load_we), .wr_addr(load_addr), .wr_data(load_data)
	);

	palette_lut u_palette (
		.Clk50(Clk50), .arst_n(arst_n), .idx(idx),
		.red(pal_red), .green(pal_green), .blue(pal_blue)
	);

	pixel_compositor u_compositor (
		.Clk50(Clk50), .arst_n(arst_n),
		.s1_hit(s1_hit), .s1_valid(s1_valid), .s1_blank(s1_blank), .idx(idx),
		.pal_red(pal_red), .pal_green(pal_green), .pal_blue(pal_blue),
		.red(red), .green(green), .blue(blue), .out_valid(out_valid)
	);

endmodule

//--- tb_sprite_renderer.sv
// Testbench for sprite_renderer_top.
// Loads random sprite memory, then streams random pixels near overlapping
// sprites and compares each output colour with a reference model.

`timescale 1ns/1ps
`include "sprite_config.svh"

module tb_sprite_renderer
	import sprite_pkg::*;
;

	localparam int CLK_PERIOD = 20;
	localparam int MEM_WORDS = 3 * `SPR_DIM * `SPR_DIM;
	localparam int NUM_PIXELS = 2000;

	logic Clk50;
	logic arst_n;
	logic pix_valid;
	logic blank;
	coord_t draw_x;
	coord_t draw_y;
	coord_t runner_x;
	coord_t runner_y;
	coord_t cactus_x;
	coord_t cactus_y;
	coord_t cloud_x;
	coord_t cloud_y;
	logic load_we;
	spr_addr_t load_addr;
	cidx_t load_data;
	chan_t red;
	chan_t green;
	chan_t blue;
	logic out_valid;

	// model state
	logic [31:0] rng_state;
	cidx_t model_mem [0:MEM_WORDS-1];
	bit exp_valid_q [$];
	logic [23:0] exp_rgb_q [$];
	string exp_name_q [$];

	sprite_renderer_top u_dut (.*);

	initial
	begin
		Clk50 = 1'b0;
		forever #(CLK_PERIOD / 2) Clk50 = ~Clk50;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// window test, no wrap past the coordinate range
	function automatic bit covers(input coord_t x, input coord_t y,
		input coord_t px, input coord_t py);
		return (x >= px) && (int'(x) - int'(px) < `SPR_DIM)
			&& (y >= py) && (int'(y) - int'(py) < `SPR_DIM);
	endfunction

	function automatic int sprite_offset(input coord_t x, input coord_t y,
		input coord_t px, input coord_t py);
		return (int'(y) - int'(py)) * `SPR_DIM + (int'(x) - int'(px));
	endfunction

	// reference colour for one pixel, tag names the case
	function automatic logic [23:0] expected_colour(input coord_t x, input coord_t y,
		input logic blk, output string tag);
		int addr;
		int covered;
		cidx_t idx;
		covered = 0;
		addr = 0;
		// lowest priority first, higher layers overwrite
		if (covers(x, y, cloud_x, cloud_y))
		begin
			covered++;
			addr = `CLOUD_BASE + sprite_offset(x, y, cloud_x, cloud_y);
		end
		if (covers(x, y, cactus_x, cactus_y))
		begin
			covered++;
			addr = `CACTUS_BASE + sprite_offset(x, y, cactus_x, cactus_y);
		end
		if (covers(x, y, runner_x, runner_y))
		begin
			covered++;
			addr = `RUNNER_BASE + sprite_offset(x, y, runner_x, runner_y);
		end
		if (blk)
		begin
			tag = "blank";
			return 24'h000000;
		end
		if (covered == 0)
		begin
			tag = "background";
			return {3{`BG_LEVEL}};
		end
		tag = (covered > 1) ? "overlap" : "sprite";
		idx = model_mem[addr];
		// transparent winner shows grey, never the layer below
		if (idx == '0)
			return {3{`BG_LEVEL}};
		return {palette_table[idx][0], palette_table[idx][1], palette_table[idx][2]};
	endfunction

	task automatic push_expected(input bit v, input logic [23:0] rgb, input string name);
		exp_valid_q.push_back(v);
		exp_rgb_q.push_back(rgb);
		exp_name_q.push_back(name);
	endtask

	// oldest entry is the pixel driven PIPE_LAT cycles ago
	task automatic check_output();
		bit v;
		logic [23:0] rgb;
		string name;
		v = exp_valid_q.pop_front();
		rgb = exp_rgb_q.pop_front();
		name = exp_name_q.pop_front();
		assert (out_valid === v)
		else
		begin
			$display("CHECK FAILED %s: out_valid expected %0b actual %0b", name, v, out_valid);
			abort_run();
		end
		if (v)
		begin
			assert ({red, green, blue} === rgb)
			else
			begin
				$display("CHECK FAILED %s: rgb expected %06h actual %06h",
					name, rgb, {red, green, blue});
				abort_run();
			end
		end
	endtask

	// all three windows overlap for any offsets drawn here
	task automatic place_sprites();
		runner_x = coord_t'(100 + next_random() % 8);
		runner_y = coord_t'(100 + next_random() % 8);
		cactus_x = coord_t'(106 + next_random() % 8);
		cactus_y = coord_t'(104 + next_random() % 8);
		cloud_x = coord_t'(104 + next_random() % 8);
		cloud_y = coord_t'(98 + next_random() % 8);
	endtask

	// one pixel, mostly near the sprites, with gaps and blanking
	task automatic drive_pixel();
		logic [31:0] r;
		logic [23:0] rgb;
		string name;
		r = next_random();
		pix_valid = (r[2:0] != 3'd0);
		blank = (r[5:3] == 3'd0);
		if (r[9:8] != 2'd0)
		begin
			draw_x = coord_t'(94 + next_random() % 40);
			draw_y = coord_t'(94 + next_random() % 40);
		end
		else
		begin
			draw_x = coord_t'(next_random());
			draw_y = coord_t'(next_random());
		end
		rgb = expected_colour(draw_x, draw_y, blank, name);
		if (!pix_valid)
			name = "gap";
		push_expected(pix_valid, rgb, name);
	endtask

	// --------------------------------------------------
	// watchdog
	// --------------------------------------------------
	initial
	begin
		#((MEM_WORDS + NUM_PIXELS + 50) * CLK_PERIOD);
		$display("watchdog: the run did not finish within its cycle budget");
		abort_run();
	end

	// --------------------------------------------------
	// bound assertion monitor
	// --------------------------------------------------
	initial
	begin
		wait (u_dut.u_asserts.err_count != 0);
		$display("a bound assertion in the DUT failed, see the error above");
		abort_run();
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		arst_n = 1'b0;
		pix_valid = 1'b0;
		blank = 1'b0;
		draw_x = '0;
		draw_y = '0;
		runner_x = '0;
		runner_y = '0;
		cactus_x = '0;
		cactus_y = '0;
		cloud_x = '0;
		cloud_y = '0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		rng_state = 32'd34322;
		repeat (2) @(posedge Clk50);
		#2;
		assert (out_valid === 1'b0 && {red, green, blue} === 24'h000000)
		else
		begin
			$display("CHECK FAILED reset: expected 0 000000 actual %0b %06h",
				out_valid, {red, green, blue});
			abort_run();
		end
		arst_n = 1'b1;

		// fill memory, about a quarter of the words transparent
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			@(posedge Clk50);
			#2;
			assert (out_valid === 1'b0)
			else
			begin
				$display("CHECK FAILED load_idle: out_valid expected 0 actual %0b", out_valid);
				abort_run();
			end
			load_we = 1'b1;
			load_addr = spr_addr_t'(i);
			load_data = (next_random() % 4 == 0) ? '0 : cidx_t'(next_random());
			model_mem[i] = load_data;
		end

		// idle pixels already in the pipe
		repeat (`PIPE_LAT) push_expected(1'b0, 24'h000000, "idle");
		for (int n = 0; n < NUM_PIXELS; n++)
		begin
			@(posedge Clk50);
			#2;
			check_output();
			load_we = 1'b0;
			if (n % 400 == 0)
				place_sprites();
			drive_pixel();
		end

		// drain the pipe
		repeat (`PIPE_LAT)
		begin
			@(posedge Clk50);
			#2;
			check_output();
			pix_valid = 1'b0;
			blank = 1'b0;
			push_expected(1'b0, 24'h000000, "drain");
		end
		$display("Verification passed");
		$finish;
	end

endmodule

//--- tb_sprite_renderer_asserts.sv
// Concurrent checks on the renderer pipe, bound into sprite_renderer_top.
// Covers output latency, blanking and the arbiter layer tag.

`timescale 1ns/1ps
`include "sprite_config.svh"

module tb_sprite_renderer_asserts
	import sprite_pkg::*;
(
	input logic Clk50,
	input logic arst_n,
	input logic pix_valid,
	input logic blank,
	input logic out_valid,
	input chan_t red,
	input chan_t green,
	input chan_t blue,
	input logic s1_hit,
	input layer_e s1_layer
);

	// failed assertion count
	int err_count = 0;

	// --------------------------------------------------
	// pipe timing, only once reset is PIPE_LAT cycles old
	// --------------------------------------------------
	assert property (@(posedge Clk50) disable iff (!arst_n)
		$past(arst_n, `PIPE_LAT) |-> out_valid == $past(pix_valid, `PIPE_LAT))
	else
	begin
		err_count++;
		$error("out_valid does not follow pix_valid after the pipe latency");
	end

	// blanked input comes out black
	assert property (@(posedge Clk50) disable iff (!arst_n)
		$past(arst_n, `PIPE_LAT) && $past(blank, `PIPE_LAT)
		|-> red == '0 && green == '0 && blue == '0)
	else
	begin
		err_count++;
		$error("a blanked pixel did not come out black");
	end

	// layer tag matches the stage 1 hit
	assert property (@(posedge Clk50) disable iff (!arst_n)
		!s1_hit |-> s1_layer == NONE)
	else
	begin
		err_count++;
		$error("a layer is tagged although no sprite was hit");
	end

endmodule

bind sprite_renderer_top tb_sprite_renderer_asserts u_asserts (
	.Clk50(Clk50), .arst_n(arst_n), .pix_valid(pix_valid), .blank(blank),
	.out_valid(out_valid), .red(red), .green(green), .blue(blue),
	.s1_hit(s1_hit), .s1_layer(s1_layer)
);
